// ==== source/fetch_pkg.sv ====
// Fetch stage shared definitions
// Widths, block types and the boot address used by every fetch block

`default_nettype none

package fetch_pkg;

    ////////////////////
    // Block geometry
    ////////////////////
    localparam int FETCH_WIDTH = 4;                   // Instructions per fetch block
    localparam int SLOT_W      = 2;                   // Bits in a slot number

    ////////////////////
    // Types
    ////////////////////
    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] inst_t;

    // Cache read data and packet payload
    typedef inst_t [FETCH_WIDTH-1:0] block_t;

    typedef logic [FETCH_WIDTH-1:0] slot_mask_t;      // One bit per slot
    typedef logic [SLOT_W-1:0]      slot_t;

    // Boot ROM entry
    localparam vaddr_t RESET_PC = 32'hbfc0_0000;

endpackage

`default_nettype wire

// ==== source/pc_register.sv ====
// PC register
// Holds the fetch PC, issues one block request per accept to the
// instruction cache and picks the next PC from redirects or prediction

`timescale 1ns/1ns
`default_nettype none

module pc_register (
    input  wire                     clk,
    input  wire                     arst_n_i,
    input  wire                     inst_index_ok_i,
    input  wire                     stop_fetch_i,
    input  wire                     trace_allowin_i,
    input  wire                     exc_occur_i,
    input  wire                     flush_i,
    input  wire                     pred_take_i,
    input  wire fetch_pkg::vaddr_t  exc_dest_i,
    input  wire fetch_pkg::vaddr_t  flush_dest_i,
    input  wire fetch_pkg::vaddr_t  pred_dest_i,
    output logic                    inst_req_o,
    output fetch_pkg::vaddr_t       inst_index_o,
    output fetch_pkg::vaddr_t       pc_o,
    output logic                    accept_o
);

    fetch_pkg::vaddr_t pc_q;
    fetch_pkg::vaddr_t pc_d;
    fetch_pkg::vaddr_t block_base;
    logic              req_en_q;       // Low for the first cycle out of reset

    assign block_base = {pc_q[31:4], 4'b0000};

    ////////////////////
    // Cache request
    ////////////////////
    assign inst_req_o   = req_en_q & ~stop_fetch_i & trace_allowin_i;
    assign inst_index_o = block_base;
    assign accept_o     = inst_req_o & inst_index_ok_i;
    assign pc_o         = pc_q;

    ////////////////////
    // Next PC
    ////////////////////
    always_comb begin
        pc_d = pc_q;
        if (exc_occur_i) begin
            pc_d = exc_dest_i;                  // Exception wins over flush
        end else if (flush_i) begin
            pc_d = flush_dest_i;
        end else if (accept_o) begin
            if (pred_take_i) begin
                pc_d = pred_dest_i;
            end else begin
                pc_d = block_base + 32'd16;     // Next sequential block
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q     <= fetch_pkg::RESET_PC;
            req_en_q <= 1'b0;
        end else begin
            pc_q     <= pc_d;
            req_en_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/branch_target_buffer.sv ====
// Branch target buffer
// Direct mapped, one taken branch per fetch block. Lookup is combinational
// on the current PC, training comes from branch repair flushes

`timescale 1ns/1ns
`default_nettype none

module branch_target_buffer #(
    parameter int BTB_ENTRIES = 16                  // Power of two, at least 2
) (
    input  wire                     clk,
    input  wire                     arst_n_i,
    input  wire fetch_pkg::vaddr_t  pc_i,
    input  wire                     flush_i,
    input  wire                     flush_take_i,
    input  wire fetch_pkg::vaddr_t  flush_err_pc_i,
    input  wire fetch_pkg::vaddr_t  flush_dest_i,
    output logic                    pred_take_o,
    output fetch_pkg::slot_t        pred_slot_o,
    output fetch_pkg::vaddr_t       pred_dest_o
);

    localparam int IDX_W = $clog2(BTB_ENTRIES);
    localparam int TAG_W = 28 - IDX_W;              // Above the block index

    logic [BTB_ENTRIES-1:0] valid_q;
    logic [TAG_W-1:0]       tag_q  [BTB_ENTRIES];
    fetch_pkg::slot_t       slot_q [BTB_ENTRIES];
    fetch_pkg::vaddr_t      dest_q [BTB_ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    fetch_pkg::slot_t rd_off;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;
    fetch_pkg::slot_t wr_slot;
    logic             upd_take;
    logic             upd_clear;

    ////////////////////
    // Lookup
    ////////////////////
    assign rd_idx = pc_i[4 +: IDX_W];
    assign rd_tag = pc_i[31 -: TAG_W];
    assign rd_off = pc_i[3:2];

    // Branch must sit at or after the first slot being fetched
    assign pred_take_o = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag)
                         && (slot_q[rd_idx] >= rd_off);
    assign pred_slot_o = slot_q[rd_idx];
    assign pred_dest_o = dest_q[rd_idx];

    ////////////////////
    // Update
    ////////////////////
    assign wr_idx  = flush_err_pc_i[4 +: IDX_W];
    assign wr_tag  = flush_err_pc_i[31 -: TAG_W];
    assign wr_slot = flush_err_pc_i[3:2];

    assign upd_take  = flush_i & flush_take_i;
    assign upd_clear = flush_i & ~flush_take_i & (slot_q[wr_idx] == wr_slot);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (upd_take) begin
            valid_q[wr_idx] <= 1'b1;
        end else if (upd_clear) begin
            valid_q[wr_idx] <= 1'b0;                // Branch no longer taken
        end
    end

    always_ff @(posedge clk) begin
        if (upd_take) begin
            tag_q[wr_idx]  <= wr_tag;
            slot_q[wr_idx] <= wr_slot;
            dest_q[wr_idx] <= flush_dest_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/fetch_trace.sv ====
// Fetch trace
// In order record of the requests the cache has accepted but not answered.
// A redirect marks all of them stale so their responses are dropped

`timescale 1ns/1ns
`default_nettype none

module fetch_trace #(
    parameter int TRACE_DEPTH = 4                   // At least 2
) (
    input  wire                     clk,
    input  wire                     arst_n_i,
    input  wire                     accept_i,
    input  wire fetch_pkg::vaddr_t  pc_i,
    input  wire                     pred_take_i,
    input  wire fetch_pkg::slot_t   pred_slot_i,
    input  wire fetch_pkg::vaddr_t  pred_dest_i,
    input  wire                     inst_data_ok_i,
    input  wire                     exc_occur_i,
    input  wire                     flush_i,
    output logic                    trace_allowin_o,
    output logic                    resp_valid_o,
    output fetch_pkg::vaddr_t       resp_pc_o,
    output logic                    resp_take_o,
    output fetch_pkg::slot_t        resp_slot_o,
    output fetch_pkg::vaddr_t       resp_dest_o
);

    localparam int PTR_W = $clog2(TRACE_DEPTH);

    // Record payload
    fetch_pkg::vaddr_t pc_q   [TRACE_DEPTH];
    logic              take_q [TRACE_DEPTH];
    fetch_pkg::slot_t  slot_q [TRACE_DEPTH];
    fetch_pkg::vaddr_t dest_q [TRACE_DEPTH];

    logic [TRACE_DEPTH-1:0] cancel_q;
    logic [PTR_W-1:0]       wr_ptr_q;
    logic [PTR_W-1:0]       rd_ptr_q;
    logic [PTR_W:0]         count_q;

    logic redirect;
    logic pop;

    assign redirect = exc_occur_i | flush_i;
    assign pop      = inst_data_ok_i & (count_q != '0);

    assign trace_allowin_o = (count_q != (PTR_W+1)'(TRACE_DEPTH));

    ////////////////////
    // Response side
    ////////////////////
    // A response landing in a redirect cycle is stale as well
    assign resp_valid_o = pop & ~cancel_q[rd_ptr_q] & ~redirect;
    assign resp_pc_o    = pc_q[rd_ptr_q];
    assign resp_take_o  = take_q[rd_ptr_q];
    assign resp_slot_o  = slot_q[rd_ptr_q];
    assign resp_dest_o  = dest_q[rd_ptr_q];

    ////////////////////
    // Queue control
    ////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            cancel_q <= '0;
        end else begin
            if (accept_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(TRACE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(TRACE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (accept_i && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (!accept_i && pop) begin
                count_q <= count_q - 1'b1;
            end
            // Also covers a record written in the redirect cycle
            if (redirect) begin
                cancel_q <= '1;
            end else if (accept_i) begin
                cancel_q[wr_ptr_q] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept_i) begin
            pc_q[wr_ptr_q]   <= pc_i;
            take_q[wr_ptr_q] <= pred_take_i;
            slot_q[wr_ptr_q] <= pred_slot_i;
            dest_q[wr_ptr_q] <= pred_dest_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/fetch_packer.sv ====
// Fetch packer
// Turns a surviving cache response into a registered fetch packet
// with slot enables and the branch prediction for the instruction queue

`timescale 1ns/1ns
`default_nettype none

module fetch_packer (
    input  wire                     clk,
    input  wire                     arst_n_i,
    input  wire                     resp_valid_i,
    input  wire fetch_pkg::vaddr_t  resp_pc_i,
    input  wire                     resp_take_i,
    input  wire fetch_pkg::slot_t   resp_slot_i,
    input  wire fetch_pkg::vaddr_t  resp_dest_i,
    input  wire fetch_pkg::block_t  inst_rdata_i,
    output logic                    fetch_valid_o,
    output fetch_pkg::vaddr_t       fetch_base_pc_o,
    output fetch_pkg::block_t       fetch_inst_o,
    output fetch_pkg::slot_mask_t   fetch_slot_en_o,
    output logic [2:0]              fetch_inst_num_o,
    output fetch_pkg::slot_mask_t   fetch_pred_take_o,
    output fetch_pkg::vaddr_t       fetch_pred_dest_o
);

    fetch_pkg::slot_t      first_slot;
    fetch_pkg::slot_t      last_slot;
    fetch_pkg::slot_mask_t slot_en;
    fetch_pkg::slot_mask_t take_mask;
    logic [2:0]            inst_num;

    assign first_slot = resp_pc_i[3:2];
    assign last_slot  = resp_take_i ? resp_slot_i : fetch_pkg::slot_t'(3);  // Trim after branch

    always_comb begin
        slot_en   = '0;
        take_mask = '0;
        inst_num  = '0;
        for (int i = 0; i < fetch_pkg::FETCH_WIDTH; i++) begin
            slot_en[i] = (fetch_pkg::slot_t'(i) >= first_slot)
                         && (fetch_pkg::slot_t'(i) <= last_slot);
            inst_num   = inst_num + {2'b00, slot_en[i]};
        end
        if (resp_take_i) begin
            take_mask[resp_slot_i] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fetch_valid_o <= 1'b0;
        end else begin
            fetch_valid_o <= resp_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (resp_valid_i) begin
            fetch_base_pc_o   <= {resp_pc_i[31:4], 4'b0000};
            fetch_inst_o      <= inst_rdata_i;
            fetch_slot_en_o   <= slot_en;
            fetch_inst_num_o  <= inst_num;
            fetch_pred_take_o <= take_mask;
            fetch_pred_dest_o <= resp_dest_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/instruction_fetch.sv ====
// Instruction fetch stage
// PC register, branch target buffer, fetch trace and packet builder
// between the instruction cache and the instruction queue

`timescale 1ns/1ns
`default_nettype none

module instruction_fetch #(
    parameter int BTB_ENTRIES = 16,
    parameter int TRACE_DEPTH = 4
) (
    input  wire                         clk,
    input  wire                         arst_n_i,
    // Instruction cache
    output wire                         inst_req_o,
    output wire fetch_pkg::vaddr_t      inst_index_o,
    input  wire                         inst_index_ok_i,
    input  wire                         inst_data_ok_i,
    input  wire fetch_pkg::block_t      inst_rdata_i,
    // Redirects
    input  wire                         exc_occur_i,
    input  wire fetch_pkg::vaddr_t      exc_dest_i,
    input  wire                         flush_i,
    input  wire fetch_pkg::vaddr_t      flush_err_pc_i,
    input  wire fetch_pkg::vaddr_t      flush_dest_i,
    input  wire                         flush_take_i,
    // Instruction queue
    input  wire                         stop_fetch_i,
    output wire                         fetch_valid_o,
    output wire fetch_pkg::vaddr_t      fetch_base_pc_o,
    output wire fetch_pkg::block_t      fetch_inst_o,
    output wire fetch_pkg::slot_mask_t  fetch_slot_en_o,
    output wire [2:0]                   fetch_inst_num_o,
    output wire fetch_pkg::slot_mask_t  fetch_pred_take_o,
    output wire fetch_pkg::vaddr_t      fetch_pred_dest_o
);

    ////////////////////
    // Internal nets
    ////////////////////
    wire fetch_pkg::vaddr_t pc;
    wire                    accept;
    wire                    pred_take;
    wire fetch_pkg::slot_t  pred_slot;
    wire fetch_pkg::vaddr_t pred_dest;
    wire                    trace_allowin;
    wire                    resp_valid;
    wire fetch_pkg::vaddr_t resp_pc;
    wire                    resp_take;
    wire fetch_pkg::slot_t  resp_slot;
    wire fetch_pkg::vaddr_t resp_dest;

    pc_register u_pc_register (
        .clk             ( clk             ),
        .arst_n_i        ( arst_n_i        ),
        .inst_index_ok_i ( inst_index_ok_i ),
        .stop_fetch_i    ( stop_fetch_i    ),
        .trace_allowin_i ( trace_allowin   ),
        .exc_occur_i     ( exc_occur_i     ),
        .flush_i         ( flush_i         ),
        .pred_take_i     ( pred_take       ),
        .exc_dest_i      ( exc_dest_i      ),
        .flush_dest_i    ( flush_dest_i    ),
        .pred_dest_i     ( pred_dest       ),
        .inst_req_o      ( inst_req_o      ),
        .inst_index_o    ( inst_index_o    ),
        .pc_o            ( pc              ),
        .accept_o        ( accept          )
    );

    branch_target_buffer #(
        .BTB_ENTRIES ( BTB_ENTRIES )
    ) u_branch_target_buffer (
        .clk            ( clk            ),
        .arst_n_i       ( arst_n_i       ),
        .pc_i           ( pc             ),
        .flush_i        ( flush_i        ),
        .flush_take_i   ( flush_take_i   ),
        .flush_err_pc_i ( flush_err_pc_i ),
        .flush_dest_i   ( flush_dest_i   ),
        .pred_take_o    ( pred_take      ),
        .pred_slot_o    ( pred_slot      ),
        .pred_dest_o    ( pred_dest      )
    );

    fetch_trace #(
        .TRACE_DEPTH ( TRACE_DEPTH )
    ) u_fetch_trace (
        .clk             ( clk            ),
        .arst_n_i        ( arst_n_i       ),
        .accept_i        ( accept         ),
        .pc_i            ( pc             ),
        .pred_take_i     ( pred_take      ),
        .pred_slot_i     ( pred_slot      ),
        .pred_dest_i     ( pred_dest      ),
        .inst_data_ok_i  ( inst_data_ok_i ),
        .exc_occur_i     ( exc_occur_i    ),
        .flush_i         ( flush_i        ),
        .trace_allowin_o ( trace_allowin  ),
        .resp_valid_o    ( resp_valid     ),
        .resp_pc_o       ( resp_pc        ),
        .resp_take_o     ( resp_take      ),
        .resp_slot_o     ( resp_slot      ),
        .resp_dest_o     ( resp_dest      )
    );

    fetch_packer u_fetch_packer (
        .clk               ( clk               ),
        .arst_n_i          ( arst_n_i          ),
        .resp_valid_i      ( resp_valid        ),
        .resp_pc_i         ( resp_pc           ),
        .resp_take_i       ( resp_take         ),
        .resp_slot_i       ( resp_slot         ),
        .resp_dest_i       ( resp_dest         ),
        .inst_rdata_i      ( inst_rdata_i      ),
        .fetch_valid_o     ( fetch_valid_o     ),
        .fetch_base_pc_o   ( fetch_base_pc_o   ),
        .fetch_inst_o      ( fetch_inst_o      ),
        .fetch_slot_en_o   ( fetch_slot_en_o   ),
        .fetch_inst_num_o  ( fetch_inst_num_o  ),
        .fetch_pred_take_o ( fetch_pred_take_o ),
        .fetch_pred_dest_o ( fetch_pred_dest_o )
    );

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
// Testbench clock and reset
// Free running clock and an active low reset held for a fixed number of cycles

`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 arst_n_o = 1'b1;                 // Release off the edge
    end

endmodule

`default_nettype wire

// ==== bench/instruction_fetch_sva.sv ====
// Fetch stage protocol checks
// Cache request rules and fetch packet sanity, bound to the fetch top level

`timescale 1ns/1ns
`default_nettype none

module instruction_fetch_sva (
    input wire                          clk,
    input wire                          arst_n_i,
    input wire                          inst_req_i,
    input wire fetch_pkg::vaddr_t       inst_index_i,
    input wire                          inst_index_ok_i,
    input wire                          stop_fetch_i,
    input wire                          exc_occur_i,
    input wire                          flush_i,
    input wire                          fetch_valid_i,
    input wire fetch_pkg::slot_mask_t   fetch_slot_en_i
);

    int error_count = 0;                    // Failed assertion count

    index_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
        inst_index_i[3:0] == 4'h0)
    else begin
        error_count++;
        $error("cache index is not block aligned");
    end

    // Held until the cache takes it, a redirect may move it
    index_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        inst_req_i && !inst_index_ok_i && !exc_occur_i && !flush_i |=> $stable(inst_index_i))
    else begin
        error_count++;
        $error("cache index changed before acceptance");
    end

    no_req_on_stop: assert property (@(posedge clk) disable iff (!arst_n_i)
        stop_fetch_i |-> !inst_req_i)
    else begin
        error_count++;
        $error("cache request issued while fetch is stopped");
    end

    quiet_in_reset: assert property (@(posedge clk) !arst_n_i |-> !fetch_valid_i)
    else begin
        error_count++;
        $error("fetch packet valid during reset");
    end

    slots_present: assert property (@(posedge clk) disable iff (!arst_n_i)
        fetch_valid_i |-> fetch_slot_en_i != '0)
    else begin
        error_count++;
        $error("fetch packet without enabled slots");
    end

endmodule

bind instruction_fetch instruction_fetch_sva u_sva (
    .clk             ( clk             ),
    .arst_n_i        ( arst_n_i        ),
    .inst_req_i      ( inst_req_o      ),
    .inst_index_i    ( inst_index_o    ),
    .inst_index_ok_i ( inst_index_ok_i ),
    .stop_fetch_i    ( stop_fetch_i    ),
    .exc_occur_i     ( exc_occur_i     ),
    .flush_i         ( flush_i         ),
    .fetch_valid_i   ( fetch_valid_o   ),
    .fetch_slot_en_i ( fetch_slot_en_o )
);

`default_nettype wire

// ==== bench/tb_instruction_fetch.sv ====
// Fetch stage testbench
// Cache model with random latency, stalls and redirects, and a reference
// model of the packet stream that every fetch packet is checked against

`timescale 1ns/1ns
`default_nettype none

module tb_instruction_fetch;

    localparam fetch_pkg::vaddr_t ERR_PC  = 32'hbfc0_0184;     // Branch in slot 1
    localparam fetch_pkg::vaddr_t TGT_PC  = 32'hbfc0_0108;     // Slot offset 2
    localparam fetch_pkg::vaddr_t NT_PC   = 32'hbfc0_0180;
    localparam fetch_pkg::vaddr_t EXC_PC  = 32'hbfc0_0380;
    localparam int                TIMEOUT = 400;

    logic                  clk;
    logic                  arst_n_i;
    logic                  inst_req_o;
    fetch_pkg::vaddr_t     inst_index_o;
    logic                  inst_index_ok_i;
    logic                  inst_data_ok_i;
    fetch_pkg::block_t     inst_rdata_i;
    logic                  exc_occur_i;
    fetch_pkg::vaddr_t     exc_dest_i;
    logic                  flush_i;
    fetch_pkg::vaddr_t     flush_err_pc_i;
    fetch_pkg::vaddr_t     flush_dest_i;
    logic                  flush_take_i;
    logic                  stop_fetch_i;
    logic                  fetch_valid_o;
    fetch_pkg::vaddr_t     fetch_base_pc_o;
    fetch_pkg::block_t     fetch_inst_o;
    fetch_pkg::slot_mask_t fetch_slot_en_o;
    logic [2:0]            fetch_inst_num_o;
    fetch_pkg::slot_mask_t fetch_pred_take_o;
    fetch_pkg::vaddr_t     fetch_pred_dest_o;

    // Reference model state
    integer            seed         = 4;
    int                cycle_count  = 0;
    int                packet_count = 0;
    fetch_pkg::vaddr_t last_base    = '0;
    fetch_pkg::vaddr_t exp_pc       = fetch_pkg::RESET_PC;
    logic              btb_valid    = 1'b0;
    fetch_pkg::vaddr_t btb_pc       = '0;
    fetch_pkg::vaddr_t btb_dest     = '0;
    fetch_pkg::vaddr_t pend_idx[$];
    int                pend_due[$];

    tb_clock_gen u_clock_gen (
        .clk_o    ( clk      ),
        .arst_n_o ( arst_n_i )
    );

    instruction_fetch #(
        .BTB_ENTRIES ( 16 ),
        .TRACE_DEPTH ( 4  )
    ) u_instruction_fetch (.*);

    function automatic fetch_pkg::inst_t cache_word(fetch_pkg::vaddr_t idx, int k);
        return (idx + 32'(4 * k)) ^ 32'h5a5a_5a5a;
    endfunction

    task automatic stop_on_error();
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] want);
        $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, want);
        stop_on_error();
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_packets(int n);
        int target;
        int waited;
        target = packet_count + n;
        waited = 0;
        while (packet_count < target) begin
            step_cycle();
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout waiting for %0d fetch packets", n);
                stop_on_error();
            end
        end
    endtask

    task automatic wait_block(fetch_pkg::vaddr_t base);
        int   seen;
        int   waited;
        logic found;
        seen   = packet_count;
        waited = 0;
        found  = 1'b0;
        while (!found) begin
            step_cycle();
            found = (packet_count != seen) && (last_base == base);
            seen  = packet_count;
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout waiting for a packet of block %08h", base);
                stop_on_error();
            end
        end
    endtask

    task automatic wait_reset();
        int waited;
        waited = 0;
        while (!arst_n_i) begin
            step_cycle();
            waited++;
            if (waited > TIMEOUT) begin
                $display("reset never released");
                stop_on_error();
            end
        end
    endtask

    task automatic pulse_flush(logic take, fetch_pkg::vaddr_t err_pc,
                               fetch_pkg::vaddr_t dest, logic with_exc);
        flush_i        = 1'b1;
        flush_take_i   = take;
        flush_err_pc_i = err_pc;
        flush_dest_i   = dest;
        exc_occur_i    = with_exc;
        exc_dest_i     = EXC_PC;
        step_cycle();
        flush_i     = 1'b0;
        exc_occur_i = 1'b0;
    endtask

    task automatic check_packet();
        fetch_pkg::vaddr_t     base;
        fetch_pkg::slot_mask_t exp_en;
        fetch_pkg::slot_mask_t exp_take;
        logic [2:0]            exp_num;
        logic                  hit;
        base     = {exp_pc[31:4], 4'h0};
        hit      = btb_valid && (btb_pc[31:4] == exp_pc[31:4]) && (btb_pc[3:2] >= exp_pc[3:2]);
        exp_en   = '0;
        exp_take = '0;
        exp_num  = '0;
        for (int k = 0; k < fetch_pkg::FETCH_WIDTH; k++) begin
            // From the fetch offset up to a predicted branch
            if (k >= exp_pc[3:2] && (!hit || k <= btb_pc[3:2])) begin
                exp_en[k] = 1'b1;
                exp_num   = exp_num + 3'd1;
            end
        end
        if (hit) begin
            exp_take[btb_pc[3:2]] = 1'b1;
        end
        assert (fetch_base_pc_o == base)
            else report_mismatch("fetch_base_pc_o", fetch_base_pc_o, base);
        assert (fetch_slot_en_o == exp_en)
            else report_mismatch("fetch_slot_en_o", fetch_slot_en_o, exp_en);
        assert (fetch_inst_num_o == exp_num)
            else report_mismatch("fetch_inst_num_o", fetch_inst_num_o, exp_num);
        assert (fetch_pred_take_o == exp_take)
            else report_mismatch("fetch_pred_take_o", fetch_pred_take_o, exp_take);
        for (int k = 0; k < fetch_pkg::FETCH_WIDTH; k++) begin
            assert (fetch_inst_o[k] == cache_word(base, k))
                else report_mismatch("fetch_inst_o", fetch_inst_o[k], cache_word(base, k));
        end
        if (hit) begin
            assert (fetch_pred_dest_o == btb_dest)
                else report_mismatch("fetch_pred_dest_o", fetch_pred_dest_o, btb_dest);
        end
        exp_pc       = hit ? btb_dest : base + 32'd16;
        last_base    = base;
        packet_count = packet_count + 1;
    endtask

    ////////////////////
    // Cache model
    ////////////////////
    initial begin : cache_model
        int lat;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (!arst_n_i) begin
                pend_idx.delete();
                pend_due.delete();
            end else if (inst_req_o && inst_index_ok_i) begin
                lat = 1 + ($random(seed) & 3);
                pend_idx.push_back(inst_index_o);
                pend_due.push_back(cycle_count + lat);
            end
            #1;
            inst_index_ok_i = ($random(seed) & 3) != 0;    // About three in four
            if (pend_idx.size() != 0 && pend_due[0] <= cycle_count) begin
                for (int k = 0; k < fetch_pkg::FETCH_WIDTH; k++) begin
                    inst_rdata_i[k] = cache_word(pend_idx[0], k);
                end
                inst_data_ok_i = 1'b1;
                void'(pend_idx.pop_front());
                void'(pend_due.pop_front());
            end else begin
                inst_data_ok_i = 1'b0;
            end
        end
    end

    ////////////////////
    // Packet monitor
    ////////////////////
    always @(posedge clk) begin
        if (arst_n_i) begin
            if (fetch_valid_o) begin
                check_packet();
            end
            if (exc_occur_i) begin
                exp_pc = exc_dest_i;
            end else if (flush_i) begin
                exp_pc = flush_dest_i;
            end
            if (flush_i && flush_take_i) begin
                btb_valid = 1'b1;
                btb_pc    = flush_err_pc_i;
                btb_dest  = flush_dest_i;
            end else if (flush_i && btb_pc[31:2] == flush_err_pc_i[31:2]) begin
                btb_valid = 1'b0;
            end
        end
    end

    // Bound protocol checks
    always @(posedge clk) begin
        if (u_instruction_fetch.u_sva.error_count != 0) begin
            $display("protocol assertion failed on the fetch ports");
            stop_on_error();
        end
    end

    initial begin
        inst_index_ok_i = 1'b0;
        inst_data_ok_i  = 1'b0;
        inst_rdata_i    = '0;
        exc_occur_i     = 1'b0;
        exc_dest_i      = '0;
        flush_i         = 1'b0;
        flush_err_pc_i  = '0;
        flush_dest_i    = '0;
        flush_take_i    = 1'b0;
        stop_fetch_i    = 1'b0;
        wait_reset();
        wait_packets(12);                       // Straight line from boot
        repeat (3) begin
            stop_fetch_i = 1'b1;
            repeat (6) step_cycle();
            stop_fetch_i = 1'b0;
            wait_packets(3);
        end
        // Taken repair trains the BTB, fetch loops back to the error block
        pulse_flush(1'b1, ERR_PC, TGT_PC, 1'b0);
        wait_block({ERR_PC[31:4], 4'h0});
        wait_block({TGT_PC[31:4], 4'h0});
        wait_packets(10);
        pulse_flush(1'b0, ERR_PC, NT_PC, 1'b0);
        wait_block(NT_PC);
        wait_packets(4);
        pulse_flush(1'b1, 32'hbfc0_0204, TGT_PC, 1'b1);    // Exception wins
        wait_block(EXC_PC);
        wait_packets(6);
        if (u_instruction_fetch.u_sva.error_count == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("%0d protocol assertion failures", u_instruction_fetch.u_sva.error_count);
            stop_on_error();
        end
    end

endmodule

`default_nettype wire

// ==== flist.f ====
source/fetch_pkg.sv
source/pc_register.sv
source/branch_target_buffer.sv
source/fetch_trace.sv
source/fetch_packer.sv
source/instruction_fetch.sv
bench/tb_clock_gen.sv
bench/instruction_fetch_sva.sv
bench/tb_instruction_fetch.sv
